// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = scmi_mbox_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/scmi_mbox_pkg.sv
hw/scmi_mbox_bus_if.sv
hw/scmi_mbox_port.sv
hw/scmi_mbox_arbiter.sv
hw/scmi_mbox_shared_mem.sv
hw/scmi_mbox_top.sv
dv/scmi_mbox_tb.sv

// File: dv/scmi_mbox_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SCMI mailbox top level.
// Runs random four-phase accesses on both ports and checks read data
// and interrupt lines against a reference model of the channel memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scmi_mbox_tb;

  localparam int AGENT    = 0;
  localparam int PLATFORM = 1;

  localparam int RESET_READS   = 16;
  localparam int PAYLOAD_PAIRS = 20;
  localparam int FLAG_WRITES   = 12;
  localparam int CONC_ACCESSES = 40;
  localparam int HOLD_ACCESSES = 8;
  localparam int LONG_HOLD     = 6;

  // ack falls one cycle after req, one more if the internal bus ack is still high
  localparam int ACK_DROP_CYCLES = 2;

  // payload pairs run in both directions and every flag write is read back
  localparam int TOTAL_TRANS = RESET_READS + 4 * PAYLOAD_PAIRS + 4 * FLAG_WRITES
                             + 2 * CONC_ACCESSES + HOLD_ACCESSES;
  localparam int CYCLES_PER_TRANS = 50;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      agent_req_i;
  logic                      agent_we_i;
  scmi_mbox_pkg::addr_t      agent_addr_i;
  scmi_mbox_pkg::data_t      agent_wdata_i;
  logic                      agent_ack_o;
  scmi_mbox_pkg::data_t      agent_rdata_o;
  logic                      platform_req_i;
  logic                      platform_we_i;
  scmi_mbox_pkg::addr_t      platform_addr_i;
  scmi_mbox_pkg::data_t      platform_wdata_i;
  logic                      platform_ack_o;
  scmi_mbox_pkg::data_t      platform_rdata_o;
  scmi_mbox_pkg::chan_vec_t  irq_doorbell_o;
  scmi_mbox_pkg::chan_vec_t  irq_completion_o;

  integer seed;

  // reference copy of the channel memory
  scmi_mbox_pkg::data_t
    model_payload [scmi_mbox_pkg::NUM_CHANNELS][scmi_mbox_pkg::NUM_PAYLOAD_WORDS];
  scmi_mbox_pkg::chan_vec_t model_doorbell;
  scmi_mbox_pkg::chan_vec_t model_completion;

  scmi_mbox_top dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .agent_req_i      (agent_req_i),
    .agent_we_i       (agent_we_i),
    .agent_addr_i     (agent_addr_i),
    .agent_wdata_i    (agent_wdata_i),
    .agent_ack_o      (agent_ack_o),
    .agent_rdata_o    (agent_rdata_o),
    .platform_req_i   (platform_req_i),
    .platform_we_i    (platform_we_i),
    .platform_addr_i  (platform_addr_i),
    .platform_wdata_i (platform_wdata_i),
    .platform_ack_o   (platform_ack_o),
    .platform_rdata_o (platform_rdata_o),
    .irq_doorbell_o   (irq_doorbell_o),
    .irq_completion_o (irq_completion_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #5 clk_i = ~clk_i;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int rand_range(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic scmi_mbox_pkg::data_t rand_word();
    scmi_mbox_pkg::data_t w;
    w = $random(seed);
    return w;
  endfunction

  function automatic string port_name(input int port);
    return (port == AGENT) ? "agent" : "platform";
  endfunction

  function automatic logic port_ack(input int port);
    return (port == AGENT) ? agent_ack_o : platform_ack_o;
  endfunction

  function automatic scmi_mbox_pkg::data_t port_rdata(input int port);
    return (port == AGENT) ? agent_rdata_o : platform_rdata_o;
  endfunction

  // flags hold a single bit and read back with zeros above it
  function automatic scmi_mbox_pkg::data_t model_read(input scmi_mbox_pkg::addr_t addr);
    scmi_mbox_pkg::chan_t     chan;
    scmi_mbox_pkg::word_off_t off;
    chan = addr[scmi_mbox_pkg::ADDR_W-1:scmi_mbox_pkg::WORD_W];
    off  = addr[scmi_mbox_pkg::WORD_W-1:0];
    if (off == scmi_mbox_pkg::DOORBELL_OFFSET) begin
      return {31'd0, model_doorbell[chan]};
    end else if (off == scmi_mbox_pkg::COMPLETION_OFFSET) begin
      return {31'd0, model_completion[chan]};
    end
    return model_payload[chan][off];
  endfunction

  task automatic model_write(input scmi_mbox_pkg::addr_t addr, input scmi_mbox_pkg::data_t wdata);
    scmi_mbox_pkg::chan_t     chan;
    scmi_mbox_pkg::word_off_t off;
    chan = addr[scmi_mbox_pkg::ADDR_W-1:scmi_mbox_pkg::WORD_W];
    off  = addr[scmi_mbox_pkg::WORD_W-1:0];
    if (off == scmi_mbox_pkg::DOORBELL_OFFSET) begin
      model_doorbell[chan] = wdata[0];
    end else if (off == scmi_mbox_pkg::COMPLETION_OFFSET) begin
      model_completion[chan] = wdata[0];
    end else begin
      model_payload[chan][off] = wdata;
    end
  endtask

  task automatic drive_port(input int port, input logic req, input logic we,
                            input scmi_mbox_pkg::addr_t addr, input scmi_mbox_pkg::data_t wdata);
    if (port == AGENT) begin
      agent_req_i   = req;
      agent_we_i    = we;
      agent_addr_i  = addr;
      agent_wdata_i = wdata;
    end else begin
      platform_req_i   = req;
      platform_we_i    = we;
      platform_addr_i  = addr;
      platform_wdata_i = wdata;
    end
  endtask

  task automatic check_irq();
    check(32'(irq_doorbell_o), 32'(model_doorbell), "doorbell interrupt vector");
    check(32'(irq_completion_o), 32'(model_completion), "completion interrupt vector");
  endtask

  // one four-phase access that holds req for hold cycles after ack
  task automatic access(input int port, input logic we, input scmi_mbox_pkg::addr_t addr,
                        input scmi_mbox_pkg::data_t wdata, input int hold);
    scmi_mbox_pkg::chan_t     chan;
    scmi_mbox_pkg::word_off_t off;
    string                    tag;
    int                       waited;
    chan = addr[scmi_mbox_pkg::ADDR_W-1:scmi_mbox_pkg::WORD_W];
    off  = addr[scmi_mbox_pkg::WORD_W-1:0];
    tag  = $sformatf("%s access to %h", port_name(port), addr);
    @(negedge clk_i);
    drive_port(port, 1'b1, we, addr, wdata);
    @(negedge clk_i);
    while (!port_ack(port)) begin
      @(negedge clk_i);
    end
    if (we) begin
      model_write(addr, wdata);
      if (off == scmi_mbox_pkg::DOORBELL_OFFSET) begin
        check(32'(irq_doorbell_o[chan]), 32'(model_doorbell[chan]), {tag, " doorbell irq"});
      end else if (off == scmi_mbox_pkg::COMPLETION_OFFSET) begin
        check(32'(irq_completion_o[chan]), 32'(model_completion[chan]), {tag, " completion irq"});
      end
    end else begin
      check(port_rdata(port), model_read(addr), {tag, " read data"});
    end
    repeat (hold) begin
      @(negedge clk_i);
      check(32'(port_ack(port)), 32'd1, {tag, " ack while req held"});
    end
    drive_port(port, 1'b0, we, addr, wdata);
    waited = 0;
    while (port_ack(port)) begin
      if (waited == ACK_DROP_CYCLES) begin
        $display("Regression failed");
        $fatal(1, "%s ack stayed high after req dropped", tag);
      end
      @(negedge clk_i);
      waited++;
    end
  endtask

  task automatic test_payload(input int writer, input int reader);
    scmi_mbox_pkg::addr_t addr;
    for (int i = 0; i < PAYLOAD_PAIRS; i++) begin
      addr = {scmi_mbox_pkg::chan_t'(rand_range(scmi_mbox_pkg::NUM_CHANNELS)),
              scmi_mbox_pkg::word_off_t'(rand_range(scmi_mbox_pkg::NUM_PAYLOAD_WORDS))};
      access(writer, 1'b1, addr, rand_word(), rand_range(4));
      access(reader, 1'b0, addr, '0, rand_range(4));
    end
  endtask

  task automatic test_flag(input scmi_mbox_pkg::word_off_t off);
    scmi_mbox_pkg::addr_t addr;
    int                   writer;
    for (int i = 0; i < FLAG_WRITES; i++) begin
      addr   = {scmi_mbox_pkg::chan_t'(rand_range(scmi_mbox_pkg::NUM_CHANNELS)), off};
      writer = rand_range(2);
      access(writer, 1'b1, addr, rand_word(), rand_range(4));
      check_irq();
      access(1 - writer, 1'b0, addr, '0, rand_range(4));
    end
  endtask

  // each port stays on its own pair of channels
  task automatic run_port_traffic(input int port, input int base_chan);
    scmi_mbox_pkg::addr_t addr;
    for (int i = 0; i < CONC_ACCESSES; i++) begin
      addr = {scmi_mbox_pkg::chan_t'(base_chan + rand_range(2)),
              scmi_mbox_pkg::word_off_t'(rand_range(8))};
      access(port, logic'(rand_range(2)), addr, rand_word(), rand_range(4));
    end
  endtask

  task automatic test_handshake();
    scmi_mbox_pkg::addr_t addr;
    int                   port;
    for (int i = 0; i < HOLD_ACCESSES / 2; i++) begin
      port = i % 2;
      addr = {scmi_mbox_pkg::chan_t'(rand_range(scmi_mbox_pkg::NUM_CHANNELS)),
              scmi_mbox_pkg::word_off_t'(rand_range(scmi_mbox_pkg::NUM_PAYLOAD_WORDS))};
      access(port, 1'b1, addr, rand_word(), LONG_HOLD);
      access(1 - port, 1'b0, addr, '0, LONG_HOLD);
      check_irq();
    end
  endtask

  initial begin
    seed = 32'h1e4d60cd;
    model_doorbell   = '0;
    model_completion = '0;
    for (int c = 0; c < scmi_mbox_pkg::NUM_CHANNELS; c++) begin
      for (int w = 0; w < scmi_mbox_pkg::NUM_PAYLOAD_WORDS; w++) begin
        model_payload[c][w] = '0;
      end
    end
    rst_n_i = 1'b0;
    drive_port(AGENT, 1'b0, 1'b0, '0, '0);
    drive_port(PLATFORM, 1'b0, 1'b0, '0, '0);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    check(32'(agent_ack_o), 32'd0, "agent ack after reset");
    check(32'(platform_ack_o), 32'd0, "platform ack after reset");
    check_irq();
    for (int i = 0; i < RESET_READS; i++) begin
      access(i % 2, 1'b0, scmi_mbox_pkg::addr_t'(rand_range(32)), '0, rand_range(4));
    end

    test_payload(AGENT, PLATFORM);
    test_payload(PLATFORM, AGENT);
    test_flag(scmi_mbox_pkg::DOORBELL_OFFSET);
    test_flag(scmi_mbox_pkg::COMPLETION_OFFSET);

    fork
      run_port_traffic(AGENT, 0);
      run_port_traffic(PLATFORM, 2);
    join
    @(negedge clk_i);
    check_irq();

    test_handshake();

    $display("Regression passed");
    $finish;
  end

  initial begin
    repeat (TOTAL_TRANS * CYCLES_PER_TRANS + 8) @(posedge clk_i);
    $display("Regression failed");
    $fatal(1, "timeout, the tests did not finish in %0d cycles",
           TOTAL_TRANS * CYCLES_PER_TRANS + 8);
  end

endmodule

// File: hw/scmi_mbox_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter between the agent and platform ports.
// One port owns the memory bus for a whole four-phase exchange.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scmi_mbox_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  scmi_mbox_bus_if.responder  port_bus [scmi_mbox_pkg::NUM_PORTS],
  scmi_mbox_bus_if.requester  mem_bus
);

  logic [scmi_mbox_pkg::NUM_PORTS-1:0] port_req;
  logic [scmi_mbox_pkg::NUM_PORTS-1:0] port_we;
  scmi_mbox_pkg::addr_t                port_addr  [scmi_mbox_pkg::NUM_PORTS];
  scmi_mbox_pkg::data_t                port_wdata [scmi_mbox_pkg::NUM_PORTS];

  logic gnt_valid_q;
  logic gnt_idx_q;
  logic last_q;
  logic pick;

  for (genvar p = 0; p < scmi_mbox_pkg::NUM_PORTS; p++) begin : g_port
    assign port_req[p]   = port_bus[p].req;
    assign port_we[p]    = port_bus[p].we;
    assign port_addr[p]  = port_bus[p].addr;
    assign port_wdata[p] = port_bus[p].wdata;

    // the port that does not hold the grant sees neither ack nor data
    assign port_bus[p].ack   = gnt_valid_q && (gnt_idx_q == p) && mem_bus.ack;
    assign port_bus[p].rdata = (gnt_valid_q && (gnt_idx_q == p)) ? mem_bus.rdata : '0;
  end

  // on a tie the port that was not served last wins
  always_comb begin
    if (port_req[0] && port_req[1]) begin
      pick = ~last_q;
    end else begin
      pick = port_req[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= 1'b0;
      // port 0 wins the first tie
      last_q      <= 1'b1;
    end else if (!gnt_valid_q) begin
      if (|port_req) begin
        gnt_valid_q <= 1'b1;
        gnt_idx_q   <= pick;
      end
    end else if (!port_req[gnt_idx_q] && !mem_bus.ack) begin
      gnt_valid_q <= 1'b0;
      last_q      <= gnt_idx_q;
    end
  end

  assign mem_bus.req   = gnt_valid_q && port_req[gnt_idx_q];
  assign mem_bus.we    = port_we[gnt_idx_q];
  assign mem_bus.addr  = port_addr[gnt_idx_q];
  assign mem_bus.wdata = port_wdata[gnt_idx_q];

endmodule

// File: hw/scmi_mbox_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase word access bus used inside the mailbox.
// A requester holds req until ack, the responder holds ack until req drops.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface scmi_mbox_bus_if;

  logic                 req;
  logic                 we;
  scmi_mbox_pkg::addr_t addr;
  scmi_mbox_pkg::data_t wdata;
  logic                 ack;

  // only meaningful for reads while ack is high
  scmi_mbox_pkg::data_t rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  modport responder (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

// File: hw/scmi_mbox_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, address map and types of the SCMI mailbox.
// Every mailbox file refers to these by scoped name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package scmi_mbox_pkg;

  // mailbox geometry
  localparam int NUM_CHANNELS = 4;

  // port 0 is the agent, port 1 is the platform
  localparam int NUM_PORTS = 2;

  localparam int CHAN_W = 2;
  localparam int WORD_W = 3;

  // word address is {channel, word offset}
  localparam int ADDR_W = CHAN_W + WORD_W;

  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [CHAN_W-1:0]       chan_t;
  typedef logic [WORD_W-1:0]       word_off_t;
  typedef logic [NUM_CHANNELS-1:0] chan_vec_t;

  // the two flag words sit at the top of each channel window
  localparam word_off_t DOORBELL_OFFSET   = 3'd6;
  localparam word_off_t COMPLETION_OFFSET = 3'd7;

  // offsets below the doorbell hold the message payload
  localparam int NUM_PAYLOAD_WORDS = int'(DOORBELL_OFFSET);

  // the requester front end waits for a request, waits on the bus and then finishes the handshake
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_BUSY,
    PORT_DONE
  } port_state_e;

endpackage

// File: hw/scmi_mbox_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end for one external four-phase requester.
// Latches the access and replays it on the internal bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scmi_mbox_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  scmi_mbox_pkg::addr_t    addr_i,
  input  scmi_mbox_pkg::data_t    wdata_i,
  output logic                    ack_o,
  output scmi_mbox_pkg::data_t    rdata_o,
  scmi_mbox_bus_if.requester      bus
);

  scmi_mbox_pkg::port_state_e state_q;

  logic                 req_q;
  logic                 ack_q;
  logic                 we_q;
  scmi_mbox_pkg::addr_t addr_q;
  scmi_mbox_pkg::data_t wdata_q;
  scmi_mbox_pkg::data_t rdata_q;

  logic accept;
  logic bus_done;

  // ack is low in idle, so a high req here is always a fresh request
  assign accept   = (state_q == scmi_mbox_pkg::PORT_IDLE) && req_i;
  assign bus_done = (state_q == scmi_mbox_pkg::PORT_BUSY) && bus.ack;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= scmi_mbox_pkg::PORT_IDLE;
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        scmi_mbox_pkg::PORT_IDLE: begin
          if (accept) begin
            req_q   <= 1'b1;
            state_q <= scmi_mbox_pkg::PORT_BUSY;
          end
        end
        scmi_mbox_pkg::PORT_BUSY: begin
          // drop the internal req right away so the arbiter can move on
          if (bus_done) begin
            req_q   <= 1'b0;
            ack_q   <= 1'b1;
            state_q <= scmi_mbox_pkg::PORT_DONE;
          end
        end
        scmi_mbox_pkg::PORT_DONE: begin
          if (!req_i && !bus.ack) begin
            ack_q   <= 1'b0;
            state_q <= scmi_mbox_pkg::PORT_IDLE;
          end
        end
        default: state_q <= scmi_mbox_pkg::PORT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (bus_done) begin
      rdata_q <= bus.rdata;
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

// File: hw/scmi_mbox_shared_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel message memory with doorbell and completion flags.
// Each flag bit drives its channel's interrupt line directly.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scmi_mbox_shared_mem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  scmi_mbox_bus_if.responder        bus,
  output scmi_mbox_pkg::chan_vec_t  irq_doorbell_o,
  output scmi_mbox_pkg::chan_vec_t  irq_completion_o
);

  scmi_mbox_pkg::data_t
    payload_q [scmi_mbox_pkg::NUM_CHANNELS][scmi_mbox_pkg::NUM_PAYLOAD_WORDS];

  scmi_mbox_pkg::chan_vec_t  doorbell_q;
  scmi_mbox_pkg::chan_vec_t  completion_q;

  scmi_mbox_pkg::chan_t      chan;
  scmi_mbox_pkg::word_off_t  off;
  scmi_mbox_pkg::data_t      rd_word;
  scmi_mbox_pkg::data_t      rdata_q;

  logic ack_q;
  logic access;

  assign chan = bus.addr[scmi_mbox_pkg::ADDR_W-1:scmi_mbox_pkg::WORD_W];
  assign off  = bus.addr[scmi_mbox_pkg::WORD_W-1:0];

  // each handshake makes one access on the edge that raises ack
  assign access = bus.req && !ack_q;

  // flags read back in bit 0 only
  always_comb begin
    case (off)
      scmi_mbox_pkg::DOORBELL_OFFSET: begin
        rd_word = scmi_mbox_pkg::data_t'(doorbell_q[chan]);
      end
      scmi_mbox_pkg::COMPLETION_OFFSET: begin
        rd_word = scmi_mbox_pkg::data_t'(completion_q[chan]);
      end
      default: begin
        rd_word = payload_q[chan][off];
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q        <= 1'b0;
      doorbell_q   <= '0;
      completion_q <= '0;
      for (int c = 0; c < scmi_mbox_pkg::NUM_CHANNELS; c++) begin
        for (int w = 0; w < scmi_mbox_pkg::NUM_PAYLOAD_WORDS; w++) begin
          payload_q[c][w] <= '0;
        end
      end
    end else if (access) begin
      ack_q <= 1'b1;
      if (bus.we) begin
        case (off)
          scmi_mbox_pkg::DOORBELL_OFFSET: begin
            doorbell_q[chan] <= bus.wdata[0];
          end
          scmi_mbox_pkg::COMPLETION_OFFSET: begin
            completion_q[chan] <= bus.wdata[0];
          end
          default: begin
            payload_q[chan][off] <= bus.wdata;
          end
        endcase
      end
    end else if (!bus.req) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !bus.we) begin
      rdata_q <= rd_word;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

  assign irq_doorbell_o   = doorbell_q;
  assign irq_completion_o = completion_q;

endmodule

// File: hw/scmi_mbox_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCMI mailbox top level with agent and platform requester ports.
// Both ports reach the shared channel memory through one arbiter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scmi_mbox_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  logic                      agent_req_i,
  input  logic                      agent_we_i,
  input  scmi_mbox_pkg::addr_t      agent_addr_i,
  input  scmi_mbox_pkg::data_t      agent_wdata_i,
  output logic                      agent_ack_o,
  output scmi_mbox_pkg::data_t      agent_rdata_o,

  input  logic                      platform_req_i,
  input  logic                      platform_we_i,
  input  scmi_mbox_pkg::addr_t      platform_addr_i,
  input  scmi_mbox_pkg::data_t      platform_wdata_i,
  output logic                      platform_ack_o,
  output scmi_mbox_pkg::data_t      platform_rdata_o,

  output scmi_mbox_pkg::chan_vec_t  irq_doorbell_o,
  output scmi_mbox_pkg::chan_vec_t  irq_completion_o
);

  // index 0 carries the agent, index 1 the platform
  scmi_mbox_bus_if port_bus [scmi_mbox_pkg::NUM_PORTS] ();
  scmi_mbox_bus_if mem_bus ();

  scmi_mbox_port u_agent_port (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (agent_req_i),
    .we_i    (agent_we_i),
    .addr_i  (agent_addr_i),
    .wdata_i (agent_wdata_i),
    .ack_o   (agent_ack_o),
    .rdata_o (agent_rdata_o),
    .bus     (port_bus[0])
  );

  scmi_mbox_port u_platform_port (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (platform_req_i),
    .we_i    (platform_we_i),
    .addr_i  (platform_addr_i),
    .wdata_i (platform_wdata_i),
    .ack_o   (platform_ack_o),
    .rdata_o (platform_rdata_o),
    .bus     (port_bus[1])
  );

  scmi_mbox_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .port_bus (port_bus),
    .mem_bus  (mem_bus)
  );

  scmi_mbox_shared_mem u_shared_mem (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bus              (mem_bus),
    .irq_doorbell_o   (irq_doorbell_o),
    .irq_completion_o (irq_completion_o)
  );

endmodule
